// ==== Makefile ====
TOP = tb_rv_decode

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f rv_decode.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f rv_decode.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -qx "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== decode_pkg.sv ====
package decode_pkg;

    typedef enum logic [4:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_mul,
        alu_div,
        alu_remu,
        alu_rem,
        alu_beq_cmp,
        alu_bne_cmp,
        alu_bge_cmp,
        alu_bltu_cmp,
        alu_bgeu_cmp
    } alu_op_t;

    typedef enum logic [1:0] {
        src_reg,      // rs1 op rs2
        src_imm,      // rs1 op imm
        src_pc_imm,   // pc + imm
        src_pc_four   // pc + 4 as link value
    } alu_src_t;

    // log2 of access bytes
    typedef logic [1:0] mem_size_t;

    localparam mem_size_t mem_byte  = 2'd0;
    localparam mem_size_t mem_half  = 2'd1;
    localparam mem_size_t mem_word  = 2'd2;
    localparam mem_size_t mem_dword = 2'd3;

    typedef struct packed {
        rv_isa_pkg::reg_idx_t rs1;
        rv_isa_pkg::reg_idx_t rs2;
        rv_isa_pkg::reg_idx_t rd;
        logic                 reg_wen;
        alu_op_t              alu_op;
        alu_src_t             alu_src;
        rv_isa_pkg::xword_t   imm;
        logic                 branch;
        logic                 jump;
        logic                 jalr;
        logic                 mem_read;
        logic                 mem_write;
        mem_size_t            mem_size;
        logic                 load_unsigned;
        logic                 word_op;   // sign-extend result from bit 31
        logic                 ebreak;
        logic                 illegal;
    } decoded_t;

    // nothing read, nothing written
    localparam decoded_t decoded_idle = '{
        rs1: '0, rs2: '0, rd: '0, reg_wen: 1'b0,
        alu_op: alu_add, alu_src: src_reg, imm: '0,
        branch: 1'b0, jump: 1'b0, jalr: 1'b0,
        mem_read: 1'b0, mem_write: 1'b0, mem_size: mem_byte, load_unsigned: 1'b0,
        word_op: 1'b0, ebreak: 1'b0, illegal: 1'b0
    };

endpackage

// ==== decode_skid_buffer.sv ====
`timescale 1ns/1ps

module decode_skid_buffer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  decode_pkg::decoded_t in_decoded,
    output logic                 out_valid,
    input  logic                 out_ready,
    output decode_pkg::decoded_t out_decoded
);

    logic                 main_valid;
    logic                 skid_valid;
    decode_pkg::decoded_t main_data;
    decode_pkg::decoded_t skid_data;
    logic                 accept_in;
    logic                 load_main;

    assign accept_in = in_valid && in_ready;
    assign load_main = !main_valid || out_ready;  // main empty or draining

    // skid entry only fills while main is stalled
    always_ff @(posedge clk) begin
        if (reset) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (load_main) begin
            main_valid <= skid_valid || accept_in;
            skid_valid <= 1'b0;
        end else if (accept_in) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load_main)
            main_data <= skid_valid ? skid_data : in_decoded;  // older item first
        if (accept_in && !load_main)
            skid_data <= in_decoded;
    end

    assign in_ready    = !skid_valid;  // low only with both entries full
    assign out_valid   = main_valid;
    assign out_decoded = main_data;

endmodule

// ==== imm_gen.sv ====
`timescale 1ns/1ps

module imm_gen (
    input  rv_isa_pkg::inst_t  inst,
    output rv_isa_pkg::xword_t imm
);

    localparam int xlen = rv_isa_pkg::xlen;

    rv_isa_pkg::opcode_t opcode;
    logic                sign;

    assign opcode = inst[rv_isa_pkg::opcode_width-1:0];
    assign sign   = inst[31];

    always_comb begin
        case (opcode)
            rv_isa_pkg::opc_op_imm,
            rv_isa_pkg::opc_op_imm_32,
            rv_isa_pkg::opc_load,
            rv_isa_pkg::opc_jalr: begin  // i format including shifts
                imm = {{(xlen-12){sign}}, inst[31:20]};
            end
            rv_isa_pkg::opc_store: begin
                imm = {{(xlen-12){sign}}, inst[31:25], inst[11:7]};
            end
            rv_isa_pkg::opc_branch: begin
                imm = {{(xlen-13){sign}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            rv_isa_pkg::opc_lui,
            rv_isa_pkg::opc_auipc: begin
                imm = {{(xlen-32){sign}}, inst[31:12], 12'b0};
            end
            rv_isa_pkg::opc_jal: begin
                imm = {{(xlen-21){sign}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: imm = '0;  // r-type, system, unknown
        endcase
    end

endmodule

// ==== opcode_decoder.sv ====
`timescale 1ns/1ps

module opcode_decoder (
    input  rv_isa_pkg::inst_t    inst,
    output decode_pkg::decoded_t ctrl
);

    rv_isa_pkg::opcode_t  opcode;
    rv_isa_pkg::funct3_t  funct3;
    rv_isa_pkg::funct7_t  funct7;
    rv_isa_pkg::reg_idx_t rd;
    rv_isa_pkg::reg_idx_t rs1;
    rv_isa_pkg::reg_idx_t rs2;
    logic [rv_isa_pkg::funct7_width-2:0] funct6;  // rv64 shift immediates
    logic                                illegal;

    assign opcode = inst[rv_isa_pkg::opcode_width-1:0];
    assign funct3 = inst[rv_isa_pkg::funct3_base +: rv_isa_pkg::funct3_width];
    assign funct7 = inst[rv_isa_pkg::funct7_base +: rv_isa_pkg::funct7_width];
    assign rd     = inst[rv_isa_pkg::rd_base +: rv_isa_pkg::reg_idx_width];
    assign rs1    = inst[rv_isa_pkg::rs1_base +: rv_isa_pkg::reg_idx_width];
    assign rs2    = inst[rv_isa_pkg::rs2_base +: rv_isa_pkg::reg_idx_width];
    assign funct6 = funct7[rv_isa_pkg::funct7_width-1:1];

    always_comb begin
        ctrl    = decode_pkg::decoded_idle;
        illegal = 1'b0;
        case (opcode)
            rv_isa_pkg::opc_op: begin
                ctrl.rs1     = rs1;
                ctrl.rs2     = rs2;
                ctrl.rd      = rd;
                ctrl.reg_wen = 1'b1;
                case (funct3)
                    rv_isa_pkg::f3_add: begin
                        if (funct7 == rv_isa_pkg::f7_base)
                            ctrl.alu_op = decode_pkg::alu_add;
                        else if (funct7 == rv_isa_pkg::f7_alt)
                            ctrl.alu_op = decode_pkg::alu_sub;
                        else
                            illegal = 1'b1;
                    end
                    rv_isa_pkg::f3_and: begin  // shared with remu
                        if (funct7 == rv_isa_pkg::f7_base)
                            ctrl.alu_op = decode_pkg::alu_and;
                        else if (funct7 == rv_isa_pkg::f7_muldiv)
                            ctrl.alu_op = decode_pkg::alu_remu;
                        else
                            illegal = 1'b1;
                    end
                    rv_isa_pkg::f3_or: begin
                        ctrl.alu_op = decode_pkg::alu_or;
                        illegal     = (funct7 != rv_isa_pkg::f7_base);
                    end
                    rv_isa_pkg::f3_sltu: begin
                        ctrl.alu_op = decode_pkg::alu_sltu;
                        illegal     = (funct7 != rv_isa_pkg::f7_base);
                    end
                    default: illegal = 1'b1;
                endcase
            end
            rv_isa_pkg::opc_op_imm: begin
                ctrl.rs1     = rs1;
                ctrl.rd      = rd;
                ctrl.reg_wen = 1'b1;
                ctrl.alu_src = decode_pkg::src_imm;
                case (funct3)
                    rv_isa_pkg::f3_add:  ctrl.alu_op = decode_pkg::alu_add;
                    rv_isa_pkg::f3_sltu: ctrl.alu_op = decode_pkg::alu_sltu;
                    rv_isa_pkg::f3_and:  ctrl.alu_op = decode_pkg::alu_and;
                    rv_isa_pkg::f3_xor:  ctrl.alu_op = decode_pkg::alu_xor;
                    rv_isa_pkg::f3_sll: begin
                        ctrl.alu_op = decode_pkg::alu_sll;
                        illegal     = (funct6 != rv_isa_pkg::f7_base[6:1]);
                    end
                    rv_isa_pkg::f3_sr: begin
                        if (funct6 == rv_isa_pkg::f7_base[6:1])
                            ctrl.alu_op = decode_pkg::alu_srl;
                        else if (funct6 == rv_isa_pkg::f7_alt[6:1])
                            ctrl.alu_op = decode_pkg::alu_sra;
                        else
                            illegal = 1'b1;
                    end
                    default: illegal = 1'b1;
                endcase
            end
            rv_isa_pkg::opc_op_32: begin
                ctrl.rs1     = rs1;
                ctrl.rs2     = rs2;
                ctrl.rd      = rd;
                ctrl.reg_wen = 1'b1;
                ctrl.word_op = 1'b1;
                case (funct3)
                    rv_isa_pkg::f3_add: begin  // addw, mulw
                        if (funct7 == rv_isa_pkg::f7_base)
                            ctrl.alu_op = decode_pkg::alu_add;
                        else if (funct7 == rv_isa_pkg::f7_muldiv)
                            ctrl.alu_op = decode_pkg::alu_mul;
                        else
                            illegal = 1'b1;
                    end
                    rv_isa_pkg::f3_sll: begin
                        ctrl.alu_op = decode_pkg::alu_sll;
                        illegal     = (funct7 != rv_isa_pkg::f7_base);
                    end
                    rv_isa_pkg::f3_divw: begin
                        ctrl.alu_op = decode_pkg::alu_div;
                        illegal     = (funct7 != rv_isa_pkg::f7_muldiv);
                    end
                    rv_isa_pkg::f3_remw: begin
                        ctrl.alu_op = decode_pkg::alu_rem;
                        illegal     = (funct7 != rv_isa_pkg::f7_muldiv);
                    end
                    default: illegal = 1'b1;
                endcase
            end
            rv_isa_pkg::opc_op_imm_32: begin  // addiw only
                ctrl.rs1     = rs1;
                ctrl.rd      = rd;
                ctrl.reg_wen = 1'b1;
                ctrl.alu_src = decode_pkg::src_imm;
                ctrl.word_op = 1'b1;
                illegal      = (funct3 != rv_isa_pkg::f3_add);
            end
            rv_isa_pkg::opc_load: begin
                ctrl.rs1      = rs1;
                ctrl.rd       = rd;
                ctrl.reg_wen  = 1'b1;
                ctrl.alu_src  = decode_pkg::src_imm;  // rs1 + offset
                ctrl.mem_read = 1'b1;
                case (funct3)
                    rv_isa_pkg::f3_lw: begin
                        ctrl.mem_size = decode_pkg::mem_word;
                        ctrl.word_op  = 1'b1;
                    end
                    rv_isa_pkg::f3_ld: ctrl.mem_size = decode_pkg::mem_dword;
                    rv_isa_pkg::f3_lbu: begin
                        ctrl.mem_size      = decode_pkg::mem_byte;
                        ctrl.load_unsigned = 1'b1;
                    end
                    default: illegal = 1'b1;
                endcase
            end
            rv_isa_pkg::opc_store: begin
                ctrl.rs1       = rs1;
                ctrl.rs2       = rs2;
                ctrl.alu_src   = decode_pkg::src_imm;
                ctrl.mem_write = 1'b1;
                case (funct3)
                    rv_isa_pkg::f3_sb: ctrl.mem_size = decode_pkg::mem_byte;
                    rv_isa_pkg::f3_sh: ctrl.mem_size = decode_pkg::mem_half;
                    rv_isa_pkg::f3_sw: ctrl.mem_size = decode_pkg::mem_word;
                    rv_isa_pkg::f3_sd: ctrl.mem_size = decode_pkg::mem_dword;
                    default: illegal = 1'b1;
                endcase
            end
            rv_isa_pkg::opc_jal: begin
                ctrl.rd      = rd;
                ctrl.reg_wen = 1'b1;
                ctrl.jump    = 1'b1;
                ctrl.alu_src = decode_pkg::src_pc_four;  // link value
            end
            rv_isa_pkg::opc_jalr: begin
                ctrl.rs1     = rs1;
                ctrl.rd      = rd;
                ctrl.reg_wen = 1'b1;
                ctrl.jump    = 1'b1;
                ctrl.jalr    = 1'b1;
                ctrl.alu_src = decode_pkg::src_pc_four;
                illegal      = (funct3 != rv_isa_pkg::f3_jalr);
            end
            rv_isa_pkg::opc_lui: begin
                ctrl.rd      = rd;
                ctrl.reg_wen = 1'b1;
                ctrl.alu_src = decode_pkg::src_imm;  // x0 + imm
            end
            rv_isa_pkg::opc_auipc: begin
                ctrl.rd      = rd;
                ctrl.reg_wen = 1'b1;
                ctrl.alu_src = decode_pkg::src_pc_imm;
            end
            rv_isa_pkg::opc_branch: begin
                ctrl.rs1    = rs1;
                ctrl.rs2    = rs2;
                ctrl.branch = 1'b1;
                case (funct3)
                    rv_isa_pkg::f3_beq:  ctrl.alu_op = decode_pkg::alu_beq_cmp;
                    rv_isa_pkg::f3_bne:  ctrl.alu_op = decode_pkg::alu_bne_cmp;
                    rv_isa_pkg::f3_bge:  ctrl.alu_op = decode_pkg::alu_bge_cmp;
                    rv_isa_pkg::f3_bltu: ctrl.alu_op = decode_pkg::alu_bltu_cmp;
                    rv_isa_pkg::f3_bgeu: ctrl.alu_op = decode_pkg::alu_bgeu_cmp;
                    default: illegal = 1'b1;
                endcase
            end
            rv_isa_pkg::opc_system: begin
                // only the exact ebreak word is kept
                if (inst == rv_isa_pkg::ebreak_word)
                    ctrl.ebreak = 1'b1;
                else
                    illegal = 1'b1;
            end
            default: illegal = 1'b1;
        endcase

        if (illegal) begin
            ctrl         = decode_pkg::decoded_idle;  // drop all side effects
            ctrl.illegal = 1'b1;
        end
    end

endmodule

// ==== rv_decode.f ====
rv_isa_pkg.sv
decode_pkg.sv
opcode_decoder.sv
imm_gen.sv
decode_skid_buffer.sv
rv_decode_top.sv
rv_decode_assertions.sv
tb_rv_decode.sv

// ==== rv_decode_assertions.sv ====
`timescale 1ns/1ps

module rv_decode_assertions (
    input logic                 clk,
    input logic                 reset,
    input logic                 out_valid,
    input logic                 out_ready,
    input decode_pkg::decoded_t out_decoded
);

    // held bundle waits for the sink
    assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_decoded))
        else $error("output bundle changed or dropped while stalled");

    assert property (@(posedge clk) reset |=> !out_valid)
        else $error("out_valid high after a reset cycle");

    assert property (@(posedge clk) disable iff (reset)
        out_valid && out_decoded.illegal |->
            !(out_decoded.reg_wen || out_decoded.mem_read || out_decoded.mem_write ||
              out_decoded.branch || out_decoded.jump))
        else $error("illegal instruction carries side-effect controls");

endmodule

bind rv_decode_top rv_decode_assertions rv_decode_assertions_inst (
    .clk         (clk),
    .reset       (reset),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_decoded (out_decoded)
);

// ==== rv_decode_top.sv ====
`timescale 1ns/1ps

module rv_decode_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  rv_isa_pkg::inst_t    inst,
    output logic                 out_valid,
    input  logic                 out_ready,
    output decode_pkg::decoded_t out_decoded
);

    decode_pkg::decoded_t decoder_ctrl;
    decode_pkg::decoded_t merged;
    rv_isa_pkg::xword_t   imm;

    opcode_decoder opcode_decoder_inst (
        .inst (inst),
        .ctrl (decoder_ctrl)
    );

    imm_gen imm_gen_inst (
        .inst (inst),
        .imm  (imm)
    );

    always_comb begin
        merged     = decoder_ctrl;
        merged.imm = imm;  // decoder leaves imm at zero
    end

    decode_skid_buffer decode_skid_buffer_inst (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_decoded  (merged),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_decoded (out_decoded)
    );

endmodule

// ==== rv_isa_pkg.sv ====
package rv_isa_pkg;

    localparam int xlen          = 64;
    localparam int inst_width    = 32;
    localparam int reg_idx_width = 5;
    localparam int opcode_width  = 7;
    localparam int funct3_width  = 3;
    localparam int funct7_width  = 7;

    localparam int rd_base     = 7;   // inst[11:7]
    localparam int funct3_base = 12;  // inst[14:12]
    localparam int rs1_base    = 15;  // inst[19:15]
    localparam int rs2_base    = 20;  // inst[24:20]
    localparam int funct7_base = 25;  // inst[31:25]

    typedef logic [inst_width-1:0]    inst_t;
    typedef logic [xlen-1:0]          xword_t;
    typedef logic [reg_idx_width-1:0] reg_idx_t;
    typedef logic [opcode_width-1:0]  opcode_t;
    typedef logic [funct3_width-1:0]  funct3_t;
    typedef logic [funct7_width-1:0]  funct7_t;

    localparam opcode_t opc_op        = 7'b0110011;
    localparam opcode_t opc_op_imm    = 7'b0010011;
    localparam opcode_t opc_op_32     = 7'b0111011;
    localparam opcode_t opc_op_imm_32 = 7'b0011011;
    localparam opcode_t opc_load      = 7'b0000011;
    localparam opcode_t opc_store     = 7'b0100011;
    localparam opcode_t opc_jal       = 7'b1101111;
    localparam opcode_t opc_jalr      = 7'b1100111;
    localparam opcode_t opc_lui       = 7'b0110111;
    localparam opcode_t opc_auipc     = 7'b0010111;
    localparam opcode_t opc_branch    = 7'b1100011;
    localparam opcode_t opc_system    = 7'b1110011;

    localparam funct3_t f3_add  = 3'b000;  // add/sub/addi/addw/mulw
    localparam funct3_t f3_sll  = 3'b001;
    localparam funct3_t f3_sltu = 3'b011;
    localparam funct3_t f3_xor  = 3'b100;
    localparam funct3_t f3_sr   = 3'b101;  // srli/srai
    localparam funct3_t f3_or   = 3'b110;
    localparam funct3_t f3_and  = 3'b111;
    localparam funct3_t f3_divw = 3'b100;
    localparam funct3_t f3_remw = 3'b110;
    localparam funct3_t f3_remu = 3'b111;
    localparam funct3_t f3_lw   = 3'b010;
    localparam funct3_t f3_ld   = 3'b011;
    localparam funct3_t f3_lbu  = 3'b100;
    localparam funct3_t f3_sb   = 3'b000;
    localparam funct3_t f3_sh   = 3'b001;
    localparam funct3_t f3_sw   = 3'b010;
    localparam funct3_t f3_sd   = 3'b011;
    localparam funct3_t f3_jalr = 3'b000;
    localparam funct3_t f3_beq  = 3'b000;
    localparam funct3_t f3_bne  = 3'b001;
    localparam funct3_t f3_bge  = 3'b101;
    localparam funct3_t f3_bltu = 3'b110;
    localparam funct3_t f3_bgeu = 3'b111;

    localparam funct7_t f7_base   = 7'b0000000;
    localparam funct7_t f7_alt    = 7'b0100000;  // sub, sra
    localparam funct7_t f7_muldiv = 7'b0000001;

    localparam inst_t ebreak_word = 32'h0010_0073;

endpackage

// ==== tb_rv_decode.sv ====
`timescale 1ns/1ps

module tb_rv_decode;

    localparam int num_insts    = 2000;
    localparam int reset_cycles = 5;
    localparam int clk_period   = 4;

    // kept encodings with all operand bits zero
    localparam logic [31:0] kept_match [35] = '{
        32'h0000_0033, 32'h4000_0033, 32'h0000_7033, 32'h0000_6033, 32'h0000_3033,
        32'h0200_7033, 32'h0000_0013, 32'h0000_3013, 32'h0000_7013, 32'h0000_4013,
        32'h0000_1013, 32'h0000_5013, 32'h4000_5013, 32'h0000_003b, 32'h0200_003b,
        32'h0000_103b, 32'h0200_403b, 32'h0200_603b, 32'h0000_001b, 32'h0000_2003,
        32'h0000_3003, 32'h0000_4003, 32'h0000_0023, 32'h0000_1023, 32'h0000_2023,
        32'h0000_3023, 32'h0000_006f, 32'h0000_0067, 32'h0000_0037, 32'h0000_0017,
        32'h0000_0063, 32'h0000_1063, 32'h0000_5063, 32'h0000_6063, 32'h0000_7063
    };

    // alu operation per entry of kept_match
    localparam decode_pkg::alu_op_t kept_op [35] = '{
        decode_pkg::alu_add, decode_pkg::alu_sub, decode_pkg::alu_and, decode_pkg::alu_or,
        decode_pkg::alu_sltu, decode_pkg::alu_remu, decode_pkg::alu_add, decode_pkg::alu_sltu,
        decode_pkg::alu_and, decode_pkg::alu_xor, decode_pkg::alu_sll, decode_pkg::alu_srl,
        decode_pkg::alu_sra, decode_pkg::alu_add, decode_pkg::alu_mul, decode_pkg::alu_sll,
        decode_pkg::alu_div, decode_pkg::alu_rem, decode_pkg::alu_add, decode_pkg::alu_add,
        decode_pkg::alu_add, decode_pkg::alu_add, decode_pkg::alu_add, decode_pkg::alu_add,
        decode_pkg::alu_add, decode_pkg::alu_add, decode_pkg::alu_add, decode_pkg::alu_add,
        decode_pkg::alu_add, decode_pkg::alu_add, decode_pkg::alu_beq_cmp, decode_pkg::alu_bne_cmp,
        decode_pkg::alu_bge_cmp, decode_pkg::alu_bltu_cmp, decode_pkg::alu_bgeu_cmp
    };

    logic                 clk;
    logic                 reset;
    logic                 in_valid;
    logic                 in_ready;
    rv_isa_pkg::inst_t    inst;
    logic                 out_valid;
    logic                 out_ready;
    decode_pkg::decoded_t out_decoded;

    decode_pkg::decoded_t expected_q[$];  // accepted but not yet out
    integer seed;
    logic   have_word     = 1'b0;
    int     issued        = 0;
    int     sent          = 0;
    int     checked       = 0;
    int     cycle         = 0;
    int     field_errors  = 0;
    int     stream_errors = 0;

    rv_decode_top rv_decode_top_inst (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .inst        (inst),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_decoded (out_decoded)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #((reset_cycles + num_insts * 8) * clk_period);
        $display("timeout: only %0d of %0d instructions accepted", sent, num_insts);
        $display("TEST FAIL");
        $finish;
    end

    // opcode and funct bits a kept encoding fixes
    function automatic logic [31:0] kept_mask(input logic [31:0] m);
        case (m[6:0])
            7'h33, 7'h3b: kept_mask = 32'hfe00_707f;
            7'h13: kept_mask = (m[13:12] == 2'b01) ? 32'hfc00_707f : 32'h0000_707f;  // shifts
            7'h6f, 7'h37, 7'h17: kept_mask = 32'h0000_007f;
            default: kept_mask = 32'h0000_707f;
        endcase
    endfunction

    function automatic rv_isa_pkg::xword_t expected_imm(input rv_isa_pkg::inst_t w);
        case (w[6:0])
            7'h13, 7'h1b, 7'h03, 7'h67: return 64'(signed'(w[31:20]));
            7'h23: return 64'(signed'({w[31:25], w[11:7]}));
            7'h63: return 64'(signed'({w[31], w[7], w[30:25], w[11:8], 1'b0}));
            7'h37, 7'h17: return 64'(signed'({w[31:12], 12'h000}));
            7'h6f: return 64'(signed'({w[31], w[19:12], w[20], w[30:21], 1'b0}));
            default: return '0;
        endcase
    endfunction

    function automatic decode_pkg::decoded_t expected_decode(input rv_isa_pkg::inst_t w);
        decode_pkg::decoded_t e;
        logic [6:0]           op;
        int                   hit;
        op  = w[6:0];
        hit = -1;
        e   = '0;
        for (int i = 0; i < 35; i++) begin
            if ((w & kept_mask(kept_match[i])) == kept_match[i])
                hit = i;
        end
        if (hit < 0) begin
            e.illegal = (w != 32'h0010_0073);  // only ebreak survives
            e.ebreak  = !e.illegal;
        end else begin
            e.alu_op = kept_op[hit];
            if (op inside {7'h33, 7'h3b, 7'h23, 7'h63, 7'h13, 7'h1b, 7'h03, 7'h67})
                e.rs1 = w[19:15];
            if (op inside {7'h33, 7'h3b, 7'h23, 7'h63})
                e.rs2 = w[24:20];
            if (!(op inside {7'h23, 7'h63})) begin
                e.rd      = w[11:7];
                e.reg_wen = 1'b1;
            end
            if (op inside {7'h13, 7'h1b, 7'h03, 7'h23, 7'h37})
                e.alu_src = decode_pkg::src_imm;
            else if (op inside {7'h6f, 7'h67})
                e.alu_src = decode_pkg::src_pc_four;
            else if (op == 7'h17)
                e.alu_src = decode_pkg::src_pc_imm;
            e.branch    = (op == 7'h63);
            e.jump      = op inside {7'h6f, 7'h67};
            e.jalr      = (op == 7'h67);
            e.mem_read  = (op == 7'h03);
            e.mem_write = (op == 7'h23);
            if (op inside {7'h03, 7'h23})
                e.mem_size = w[13:12];
            e.load_unsigned = (op == 7'h03) && w[14];
            e.word_op       = (op inside {7'h3b, 7'h1b}) || (op == 7'h03 && w[14:12] == 3'b010);
        end
        e.imm = expected_imm(w);
        return e;
    endfunction

    task automatic compare_field(input string name, input rv_isa_pkg::xword_t exp,
                                 input rv_isa_pkg::xword_t got);
        assert (exp === got) else begin
            $display("MISMATCH %s expected %h actual %h", name, exp, got);
            field_errors++;
        end
    endtask

    task automatic compare_bundle(input decode_pkg::decoded_t exp,
                                  input decode_pkg::decoded_t got);
        compare_field("rs1", 64'(exp.rs1), 64'(got.rs1));
        compare_field("rs2", 64'(exp.rs2), 64'(got.rs2));
        compare_field("rd", 64'(exp.rd), 64'(got.rd));
        compare_field("reg_wen", 64'(exp.reg_wen), 64'(got.reg_wen));
        compare_field("alu_op", 64'(exp.alu_op), 64'(got.alu_op));
        compare_field("alu_src", 64'(exp.alu_src), 64'(got.alu_src));
        compare_field("imm", exp.imm, got.imm);
        compare_field("branch", 64'(exp.branch), 64'(got.branch));
        compare_field("jump", 64'(exp.jump), 64'(got.jump));
        compare_field("jalr", 64'(exp.jalr), 64'(got.jalr));
        compare_field("mem_read", 64'(exp.mem_read), 64'(got.mem_read));
        compare_field("mem_write", 64'(exp.mem_write), 64'(got.mem_write));
        compare_field("mem_size", 64'(exp.mem_size), 64'(got.mem_size));
        compare_field("load_unsigned", 64'(exp.load_unsigned), 64'(got.load_unsigned));
        compare_field("word_op", 64'(exp.word_op), 64'(got.word_op));
        compare_field("ebreak", 64'(exp.ebreak), 64'(got.ebreak));
        compare_field("illegal", 64'(exp.illegal), 64'(got.illegal));
    endtask

    // sampled right at the edge, before the DUT registers update
    task automatic monitor_edge();
        assert (out_valid == (expected_q.size() != 0)) else begin
            $display("MISMATCH out_valid expected %h actual %h",
                     expected_q.size() != 0, out_valid);
            stream_errors++;
        end
        assert (in_ready == (expected_q.size() < 2)) else begin
            $display("MISMATCH in_ready expected %h actual %h",
                     expected_q.size() < 2, in_ready);
            stream_errors++;
        end
        if (out_valid && out_ready && expected_q.size() != 0) begin
            compare_bundle(expected_q.pop_front(), out_decoded);
            checked++;
        end
        if (in_valid && in_ready) begin
            expected_q.push_back(expected_decode(inst));
            have_word = 1'b0;
            sent++;
        end
    endtask

    task automatic drive_inputs();
        int sel;
        int idx;
        if (!have_word && issued < num_insts) begin
            sel = $random(seed) & 63;
            idx = ($random(seed) & 32'h7fff_ffff) % 35;
            inst = $random(seed);
            if (sel == 0)
                inst = 32'h0010_0073;  // ebreak
            else if (sel > 8)
                inst = (inst & ~kept_mask(kept_match[idx])) | kept_match[idx];
            have_word = 1'b1;
            issued++;
            in_valid = ($random(seed) & 3) != 0;
        end else if (have_word && !in_valid) begin
            in_valid = ($random(seed) & 3) != 0;
        end else if (!have_word) begin
            in_valid = 1'b0;
        end
        // stall window fills both entries
        out_ready = (cycle % 100 < 8) ? 1'b0 : (($random(seed) & 3) != 0);
        cycle++;
    endtask

    initial begin
        seed      = 25;
        reset     = 1'b1;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        inst      = '0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;
        while (sent < num_insts || expected_q.size() != 0) begin
            @(posedge clk);
            monitor_edge();
            #1;
            drive_inputs();
        end
        repeat (10) begin
            @(posedge clk);
            monitor_edge();
        end
        $display("errors: %0d field, %0d stream, %0d bundles compared",
                 field_errors, stream_errors, checked);
        if (field_errors == 0 && stream_errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule
